//--- build.f
hw/cascade_pkg.sv
hw/cascade_if.sv
hw/cascade_database.sv
hw/classifier_decode.sv
hw/classifier_execute.sv
hw/stage_result.sv
hw/cascade_top.sv
sim/cascade_checker.sv
sim/cascade_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the cascade testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module cascade_tb -o cascade_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/cascade_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1

//--- hw/cascade_data.hex
// one signed 16-bit word per line, per stage four records of threshold, left leaf, right leaf
// followed by the stage threshold
0100
FFC0
0050
FF00
FFA0
0040
0000
0030
FFD0
0400
0020
FF80
FFF0
0200
FF9C
0064
FE00
0032
FFCE
1000
FFE0
0060
7FFF
0010
8000
0022
F000
0028
FFD8
0080
FFB0
0070
0000
0018
FFF8
0300
FFC4
003C
0024

//--- sim/cascade_tb.sv
module cascade_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cascade_pkg::*;

	localparam int CLK_PERIOD = 10;
	localparam int SEED = 75;
	localparam int RANDOM_WINDOWS = 200;
	localparam int EDGE_WINDOWS = 5;
	localparam int GAP_WINDOWS = 50;
	localparam int MAX_GAP = 5;
	// one window each in tests 5 and 6, plus the one cut short by reset
	localparam int TOTAL_WINDOWS = RANDOM_WINDOWS + EDGE_WINDOWS + GAP_WINDOWS + 3;
	localparam int LOAD_RUNS = 3;
	localparam int MARGIN_CYCLES = 500;
	localparam int WATCHDOG_CYCLES = TOTAL_WINDOWS * NUM_FEATURES * (MAX_GAP + 1)
		+ LOAD_RUNS * (DB_WORDS + 2) + MARGIN_CYCLES;

	logic clk = 1'b0;
	logic reset;
	logic i_feature_valid;
	data_word_t i_feature;
	logic o_load_done;
	logic o_result_valid;
	logic [NUM_STAGES-1:0] o_stage_pass;
	logic o_face;
	logic test_end;
	int test_num;
	logic final_report;
	int errors;
	int pending;

	always #(CLK_PERIOD / 2) clk = ~clk;

	cascade_top uut (
		.clk             (clk),
		.reset           (reset),
		.i_feature_valid (i_feature_valid),
		.i_feature       (i_feature),
		.o_load_done     (o_load_done),
		.o_result_valid  (o_result_valid),
		.o_stage_pass    (o_stage_pass),
		.o_face          (o_face)
	);

	cascade_checker chk (
		.clk             (clk),
		.reset           (reset),
		.i_feature_valid (i_feature_valid),
		.i_feature       (i_feature),
		.i_load_done     (o_load_done),
		.i_result_valid  (o_result_valid),
		.i_stage_pass    (o_stage_pass),
		.i_face          (o_face),
		.i_test_end      (test_end),
		.i_test_num      (test_num),
		.i_final         (final_report),
		.o_errors        (errors),
		.o_pending       (pending)
	);

	// ========================================
	// stimulus helpers
	// ========================================
	task automatic idle_cycles(int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			i_feature_valid = 1'b0;
		end
	endtask

	task automatic send_feature(data_word_t value);
		@(posedge clk);
		#1;
		i_feature_valid = 1'b1;
		i_feature = value;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset = 1'b1;
		i_feature_valid = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic wait_load();
		while (o_load_done !== 1'b1)
		begin
			idle_cycles(1);
		end
	endtask

	// lets every expected verdict arrive, then reports the test
	task automatic finish_test(int num);
		idle_cycles(1);
		while (pending != 0)
		begin
			idle_cycles(1);
		end
		idle_cycles(4);
		test_num = num;
		test_end = 1'b1;
		idle_cycles(1);
		test_end = 1'b0;
	endtask

	task automatic send_random_window(int max_gap);
		for (int f = 0; f < NUM_FEATURES; f++)
		begin
			send_feature(data_word_t'($urandom()));
			idle_cycles($urandom_range(max_gap, 0));
		end
	endtask

	function automatic data_word_t db_word(int addr);
		return chk.db_words[addr];
	endfunction

	function automatic data_word_t one_below(data_word_t value);
		return (value == 16'sh8000) ? value : data_word_t'(value - 1);
	endfunction

	// leaf choice per classifier (bit set means left) that lands exactly on the stage threshold
	function automatic int exact_mask(int stage);
		int sum;
		int base;
		for (int m = 0; m < (1 << NUM_CLASSIFIERS); m++)
		begin
			sum = 0;
			for (int c = 0; c < NUM_CLASSIFIERS; c++)
			begin
				base = stage * WORDS_PER_STAGE + c * WORDS_PER_CLASSIFIER;
				sum += m[c] ? int'(db_word(base + OFS_LEFT)) : int'(db_word(base + OFS_RIGHT));
			end
			if (sum == int'(db_word(stage * WORDS_PER_STAGE + OFS_STAGE_THRESHOLD)))
			begin
				return m;
			end
		end
		return 0;
	endfunction

	task automatic send_edge_window(int kind);
		data_word_t thr;
		int mask;
		for (int s = 0; s < NUM_STAGES; s++)
		begin
			mask = exact_mask(s);
			for (int c = 0; c < NUM_CLASSIFIERS; c++)
			begin
				thr = db_word(s * WORDS_PER_STAGE + c * WORDS_PER_CLASSIFIER + OFS_THRESHOLD);
				case (kind)
					0: send_feature(thr);
					1: send_feature(one_below(thr));
					2: send_feature(16'sh8000);
					3: send_feature(16'sh7fff);
					default: send_feature(mask[c] ? one_below(thr) : thr);
				endcase
			end
		end
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial
	begin
		void'($urandom(SEED));
		reset = 1'b1;
		i_feature_valid = 1'b0;
		i_feature = '0;
		test_end = 1'b0;
		test_num = 0;
		final_report = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		wait_load();
		idle_cycles(20);
		finish_test(1);

		repeat (RANDOM_WINDOWS) send_random_window(0);
		finish_test(2);

		for (int k = 0; k < EDGE_WINDOWS; k++)
		begin
			send_edge_window(k);
		end
		finish_test(3);

		repeat (GAP_WINDOWS) send_random_window(MAX_GAP);
		finish_test(4);

		// these strobes land while the bank is still loading
		apply_reset();
		repeat (10) send_feature(data_word_t'($urandom()));
		wait_load();
		send_random_window(0);
		finish_test(5);

		repeat (5) send_feature(data_word_t'($urandom()));
		apply_reset();
		wait_load();
		send_random_window(0);
		finish_test(6);

		final_report = 1'b1;
		idle_cycles(1);
		final_report = 1'b0;
		if (errors == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("the run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- sim/cascade_checker.sv
module cascade_checker (
	input  logic clk,
	input  logic reset,
	input  logic i_feature_valid,
	input  cascade_pkg::data_word_t i_feature,
	input  logic i_load_done,
	input  logic i_result_valid,
	input  logic [cascade_pkg::NUM_STAGES-1:0] i_stage_pass,
	input  logic i_face,
	input  logic i_test_end,
	input  int i_test_num,
	input  logic i_final,
	output int o_errors,
	output int o_pending
);
	timeunit 1ns;
	timeprecision 100ps;
	import cascade_pkg::*;

	typedef struct packed {
		int due;
		logic [NUM_STAGES-1:0] pass;
	} verdict_t;

	data_word_t db_words [DB_WORDS];
	verdict_t expected [$];
	verdict_t head;
	int cyc = 0;
	int load_count = 0;
	int position = 0;
	int stage_sum = 0;
	logic [NUM_STAGES-1:0] pass_bits = '0;
	logic model_ready = 1'b0;
	logic after_reset = 1'b0;
	int errors = 0;
	int pending = 0;
	int tests = 0;
	int verdicts = 0;
	int test_verdicts = 0;
	int test_errors = 0;

	assign o_errors = errors;
	assign o_pending = pending;

	initial
	begin
		$readmemh(DB_FILE, db_words);
	end

	function automatic string test_name(int num);
		case (num)
			1: return "load completes";
			2: return "random windows";
			3: return "threshold edge cases";
			4: return "random gaps";
			5: return "features before load";
			6: return "reset in mid-window";
			default: return "unnamed";
		endcase
	endfunction

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	// ========================================
	// compare and model, once per clock
	// ========================================
	// at the falling edge the outputs show the last rising edge, and the inputs
	// hold what the next rising edge will sample
	always @(negedge clk)
	begin
		int base;
		int leaf;
		int stage;
		cyc++;
		if (model_ready)
		begin
			if (i_load_done !== (load_count == DB_WORDS))
			begin
				$display("FAIL time %0d ns: load done is %b after %0d load cycles",
					$time, i_load_done, load_count);
				count_error();
			end
			if (after_reset && (i_result_valid !== 1'b0 || i_stage_pass !== '0 || i_face !== 1'b0))
			begin
				$display("FAIL time %0d ns: result outputs not cleared by reset", $time);
				count_error();
			end
			if (i_result_valid === 1'b1)
			begin
				if (expected.size() == 0)
				begin
					$display("at %0d ns a verdict arrived that no complete window asked for", $time);
					count_error();
				end
				else
				begin
					head = expected.pop_front();
					verdicts++;
					test_verdicts++;
					if (head.due != cyc)
					begin
						$display("FAIL time %0d ns: verdict at cycle %0d, expected at cycle %0d",
							$time, cyc, head.due);
						count_error();
					end
					if (i_stage_pass !== head.pass || i_face !== &head.pass)
					begin
						$display("FAIL time %0d ns: pass bits %b face %b, expected %b face %b",
							$time, i_stage_pass, i_face, head.pass, &head.pass);
						count_error();
					end
				end
			end
			else if (expected.size() != 0 && expected[0].due <= cyc)
			begin
				$display("at %0d ns a verdict due at cycle %0d never arrived", $time, expected[0].due);
				head = expected.pop_front();
				count_error();
			end
		end

		after_reset = 1'b0;
		if (reset === 1'b1)
		begin
			// the partial window and anything still in the pipeline are lost
			load_count = 0;
			position = 0;
			stage_sum = 0;
			pass_bits = '0;
			expected.delete();
			model_ready = 1'b1;
			after_reset = 1'b1;
		end
		else if (model_ready)
		begin
			if (i_feature_valid === 1'b1 && load_count == DB_WORDS)
			begin
				stage = position / NUM_CLASSIFIERS;
				base = stage * WORDS_PER_STAGE + (position % NUM_CLASSIFIERS) * WORDS_PER_CLASSIFIER;
				leaf = (i_feature < db_words[base + OFS_THRESHOLD]) ?
					int'(db_words[base + OFS_LEFT]) : int'(db_words[base + OFS_RIGHT]);
				stage_sum += leaf;
				if (position % NUM_CLASSIFIERS == NUM_CLASSIFIERS - 1)
				begin
					pass_bits[stage] = (stage_sum >=
						int'(db_words[stage * WORDS_PER_STAGE + OFS_STAGE_THRESHOLD]));
					stage_sum = 0;
				end
				if (position == NUM_FEATURES - 1)
				begin
					// the twelfth feature is taken at the next rising edge, the verdict three later
					expected.push_back('{due: cyc + 4, pass: pass_bits});
					pass_bits = '0;
					position = 0;
				end
				else
				begin
					position++;
				end
			end
			if (load_count < DB_WORDS)
			begin
				load_count++;
			end
		end
		pending = expected.size();

		if (i_test_end === 1'b1)
		begin
			tests++;
			$display("test %0d %s: %0d verdicts, %0d errors",
				i_test_num, test_name(i_test_num), test_verdicts, test_errors);
			test_verdicts = 0;
			test_errors = 0;
		end
		if (i_final === 1'b1)
		begin
			$display("%0d tests, %0d verdicts checked, %0d errors", tests, verdicts, errors);
		end
	end

endmodule

//--- hw/cascade_top.sv
module cascade_top (
	input  logic clk,
	input  logic reset,
	input  logic i_feature_valid,
	input  cascade_pkg::data_word_t i_feature,
	output logic o_load_done,
	output logic o_result_valid,
	output logic [cascade_pkg::NUM_STAGES-1:0] o_stage_pass,
	output logic o_face
);
	import cascade_pkg::*;

	// execute to result
	logic sum_valid;
	stage_sum_t stage_sum;
	data_word_t stage_threshold;
	logic last_stage;

	db_if lookup_bus ();
	exec_if exec_bus ();

	// ========================================
	// classifier database
	// ========================================
	cascade_database u_database (
		.clk         (clk),
		.reset       (reset),
		.o_load_done (o_load_done),
		.i_lookup    (lookup_bus.db_table)
	);

	// ========================================
	// datapath
	// ========================================
	classifier_decode u_decode (
		.clk             (clk),
		.reset           (reset),
		.i_load_done     (o_load_done),
		.i_feature_valid (i_feature_valid),
		.i_feature       (i_feature),
		.o_lookup        (lookup_bus.lookup),
		.o_exec          (exec_bus.source)
	);

	classifier_execute u_execute (
		.clk               (clk),
		.reset             (reset),
		.i_exec            (exec_bus.sink),
		.o_sum_valid       (sum_valid),
		.o_stage_sum       (stage_sum),
		.o_stage_threshold (stage_threshold),
		.o_last_stage      (last_stage)
	);

	stage_result u_result (
		.clk               (clk),
		.reset             (reset),
		.i_sum_valid       (sum_valid),
		.i_stage_sum       (stage_sum),
		.i_stage_threshold (stage_threshold),
		.i_last_stage      (last_stage),
		.o_result_valid    (o_result_valid),
		.o_stage_pass      (o_stage_pass),
		.o_face            (o_face)
	);

endmodule

//--- hw/stage_result.sv
module stage_result (
	input  logic clk,
	input  logic reset,
	input  logic i_sum_valid,
	input  cascade_pkg::stage_sum_t i_stage_sum,
	input  cascade_pkg::data_word_t i_stage_threshold,
	input  logic i_last_stage,
	output logic o_result_valid,
	output logic [cascade_pkg::NUM_STAGES-1:0] o_stage_pass,
	output logic o_face
);
	import cascade_pkg::*;

	logic [STAGE_IDX_WIDTH-1:0] stage_idx;
	logic [NUM_STAGES-1:0] pass_bits;
	logic [NUM_STAGES-1:0] window_bits;
	logic stage_pass;

	// the threshold is sign extended to the sum width before comparing
	assign stage_pass = (i_stage_sum >= stage_sum_t'(i_stage_threshold));

	// pass bits so far with the current stage merged in
	always_comb
	begin
		window_bits = pass_bits;
		window_bits[stage_idx] = stage_pass;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage_idx <= '0;
			pass_bits <= '0;
			o_result_valid <= 1'b0;
			o_stage_pass <= '0;
			o_face <= 1'b0;
		end
		else
		begin
			o_result_valid <= i_sum_valid && i_last_stage;
			if (i_sum_valid && i_last_stage)
			begin
				stage_idx <= '0;
				pass_bits <= '0;
				o_stage_pass <= window_bits;
				// a face needs every stage to pass
				o_face <= &window_bits;
			end
			else if (i_sum_valid)
			begin
				stage_idx <= stage_idx + 1'b1;
				pass_bits <= window_bits;
			end
		end
	end

endmodule

//--- hw/classifier_execute.sv
module classifier_execute (
	input  logic clk,
	input  logic reset,
	exec_if.sink i_exec,
	output logic o_sum_valid,
	output cascade_pkg::stage_sum_t o_stage_sum,
	output cascade_pkg::data_word_t o_stage_threshold,
	output logic o_last_stage
);
	import cascade_pkg::*;

	data_word_t leaf;
	stage_sum_t running_sum;
	stage_sum_t partial_sum;

	// ========================================
	// leaf selection
	// ========================================
	// strictly below the threshold takes the left leaf, equal goes right
	assign leaf = (i_exec.feature < i_exec.threshold) ? i_exec.left : i_exec.right;
	assign partial_sum = running_sum + stage_sum_t'(leaf);

	// ========================================
	// stage accumulation
	// ========================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running_sum <= '0;
			o_sum_valid <= 1'b0;
		end
		else
		begin
			o_sum_valid <= i_exec.valid && i_exec.last_in_stage;
			if (i_exec.valid)
			begin
				// the next stage starts from zero
				running_sum <= i_exec.last_in_stage ? '0 : partial_sum;
			end
		end
	end

	// the full stage sum and its threshold are qualified by o_sum_valid
	always_ff @(posedge clk)
	begin
		if (i_exec.valid && i_exec.last_in_stage)
		begin
			o_stage_sum <= partial_sum;
			o_stage_threshold <= i_exec.stage_threshold;
			o_last_stage <= i_exec.last_in_window;
		end
	end

endmodule

//--- hw/classifier_decode.sv
module classifier_decode (
	input  logic clk,
	input  logic reset,
	input  logic i_load_done,
	input  logic i_feature_valid,
	input  cascade_pkg::data_word_t i_feature,
	db_if.lookup o_lookup,
	exec_if.source o_exec
);
	import cascade_pkg::*;

	logic [STAGE_IDX_WIDTH-1:0] stage_idx;
	logic [CLASS_IDX_WIDTH-1:0] class_idx;
	logic accept;
	logic feature_valid_q;
	data_word_t feature_q;
	logic last_in_stage;
	logic last_in_window;

	// strobes that arrive while the bank is still loading are dropped
	assign accept = i_feature_valid && i_load_done;
	assign last_in_stage = (class_idx == CLASS_IDX_WIDTH'(NUM_CLASSIFIERS - 1));
	assign last_in_window = last_in_stage && (stage_idx == STAGE_IDX_WIDTH'(NUM_STAGES - 1));

	assign o_lookup.stage = stage_idx;
	assign o_lookup.classifier = class_idx;

	// an accepted feature waits here for one cycle while its record is looked up
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			feature_valid_q <= 1'b0;
		end
		else
		begin
			feature_valid_q <= accept;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			feature_q <= i_feature;
		end
	end

	// position within the window wraps after the last classifier of the last stage
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stage_idx <= '0;
			class_idx <= '0;
		end
		else if (feature_valid_q)
		begin
			if (last_in_stage)
			begin
				class_idx <= '0;
				stage_idx <= last_in_window ? '0 : stage_idx + 1'b1;
			end
			else
			begin
				class_idx <= class_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_exec.valid <= 1'b0;
		end
		else
		begin
			o_exec.valid <= feature_valid_q;
		end
	end

	// the record is captured alongside its feature for the execute stage
	always_ff @(posedge clk)
	begin
		if (feature_valid_q)
		begin
			o_exec.feature <= feature_q;
			o_exec.threshold <= o_lookup.threshold;
			o_exec.left <= o_lookup.left;
			o_exec.right <= o_lookup.right;
			o_exec.stage_threshold <= o_lookup.stage_threshold;
			o_exec.last_in_stage <= last_in_stage;
			o_exec.last_in_window <= last_in_window;
		end
	end

endmodule

//--- hw/cascade_database.sv
module cascade_database (
	input  logic clk,
	input  logic reset,
	output logic o_load_done,
	db_if.db_table i_lookup
);
	import cascade_pkg::*;

	data_word_t rom [DB_WORDS];
	data_word_t bank [DB_WORDS];
	logic [DB_ADDR_WIDTH-1:0] load_addr;
	logic [DB_ADDR_WIDTH-1:0] stage_base;
	logic [DB_ADDR_WIDTH-1:0] record_base;
	logic [DB_ADDR_WIDTH-1:0] stage_thr_addr;

	// the cascade parameters are fixed at elaboration
	initial
	begin
		$readmemh(DB_FILE, rom);
	end

	// ========================================
	// load sequencer
	// ========================================
	// one word moves from the ROM into the bank per clock, then done holds
	// until the next reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			load_addr <= '0;
			o_load_done <= 1'b0;
			for (int i = 0; i < DB_WORDS; i++)
			begin
				bank[i] <= '0;
			end
		end
		else if (!o_load_done)
		begin
			bank[load_addr] <= rom[load_addr];
			if (load_addr == DB_ADDR_WIDTH'(DB_WORDS - 1))
			begin
				o_load_done <= 1'b1;
			end
			else
			begin
				load_addr <= load_addr + 1'b1;
			end
		end
	end

	// ========================================
	// record lookup
	// ========================================
	// stage and classifier indices map to word addresses in the bank
	always_comb
	begin
		stage_base = DB_ADDR_WIDTH'(i_lookup.stage) * DB_ADDR_WIDTH'(WORDS_PER_STAGE);
		record_base = stage_base
			+ DB_ADDR_WIDTH'(i_lookup.classifier) * DB_ADDR_WIDTH'(WORDS_PER_CLASSIFIER);
		stage_thr_addr = stage_base + DB_ADDR_WIDTH'(OFS_STAGE_THRESHOLD);
	end

	assign i_lookup.threshold = bank[record_base + DB_ADDR_WIDTH'(OFS_THRESHOLD)];
	assign i_lookup.left = bank[record_base + DB_ADDR_WIDTH'(OFS_LEFT)];
	assign i_lookup.right = bank[record_base + DB_ADDR_WIDTH'(OFS_RIGHT)];
	assign i_lookup.stage_threshold = bank[stage_thr_addr];

endmodule

//--- hw/cascade_if.sv
// record lookup between decode and the database register bank
interface db_if;
	logic [cascade_pkg::STAGE_IDX_WIDTH-1:0] stage;
	logic [cascade_pkg::CLASS_IDX_WIDTH-1:0] classifier;
	cascade_pkg::data_word_t threshold;
	cascade_pkg::data_word_t left;
	cascade_pkg::data_word_t right;
	cascade_pkg::data_word_t stage_threshold;

	modport lookup (output stage, output classifier,
		input threshold, input left, input right, input stage_threshold);
	// the database side answers from its register bank
	modport db_table (input stage, input classifier,
		output threshold, output left, output right, output stage_threshold);
endinterface

// decode hands execute one registered classifier item per valid strobe
interface exec_if;
	logic valid;
	cascade_pkg::data_word_t feature;
	cascade_pkg::data_word_t threshold;
	cascade_pkg::data_word_t left;
	cascade_pkg::data_word_t right;
	logic last_in_stage;
	logic last_in_window;
	cascade_pkg::data_word_t stage_threshold;

	modport source (output valid, output feature, output threshold, output left,
		output right, output last_in_stage, output last_in_window, output stage_threshold);
	modport sink (input valid, input feature, input threshold, input left,
		input right, input last_in_stage, input last_in_window, input stage_threshold);
endinterface

//--- hw/cascade_pkg.sv
package cascade_pkg;

	// ========================================
	// cascade geometry
	// ========================================
	localparam int NUM_STAGES = 3;
	localparam int NUM_CLASSIFIERS = 4;
	localparam int NUM_FEATURES = NUM_STAGES * NUM_CLASSIFIERS;
	localparam int STAGE_IDX_WIDTH = $clog2(NUM_STAGES);
	localparam int CLASS_IDX_WIDTH = $clog2(NUM_CLASSIFIERS);

	// ========================================
	// database layout
	// ========================================
	// each record holds threshold, left leaf and right leaf in that order
	localparam int WORDS_PER_CLASSIFIER = 3;
	localparam int OFS_THRESHOLD = 0;
	localparam int OFS_LEFT = 1;
	localparam int OFS_RIGHT = 2;
	// the stage threshold follows the last record of its stage
	localparam int OFS_STAGE_THRESHOLD = NUM_CLASSIFIERS * WORDS_PER_CLASSIFIER;
	localparam int WORDS_PER_STAGE = OFS_STAGE_THRESHOLD + 1;
	localparam int DB_WORDS = NUM_FEATURES * WORDS_PER_CLASSIFIER + NUM_STAGES;
	localparam int DB_ADDR_WIDTH = 6;
	localparam string DB_FILE = "hw/cascade_data.hex";

	// all words and sums are signed
	localparam int DATA_WIDTH = 16;
	localparam int SUM_WIDTH = 18;
	typedef logic signed [DATA_WIDTH-1:0] data_word_t;
	typedef logic signed [SUM_WIDTH-1:0] stage_sum_t;

endpackage
